/* Makefile */
TOOL  := verilator
FLAGS := --binary --timing --assert -Wno-fatal
TOP   := tb_rs_top
LIST  := tb.f
BUILD := obj_dir

SRCS  := $(shell grep -v '^+' $(LIST))
BIN   := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a listed source or the list changes
$(BIN): $(SRCS) $(LIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(LIST) --Mdir $(BUILD)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf $(BUILD)

/* bench/tb_rs_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rs_top;

	localparam int RS = 8;	// Station depth under test

	logic                    clock;
	logic                    reset;
	rs_pkg::dispatch_t       disp0;
	rs_pkg::dispatch_t       disp1;
	logic [$clog2(RS+1)-1:0] free_count;
	logic [$clog2(RS+1)-1:0] free_seen;	// free_count at the last falling edge
	rs_pkg::cdb_t            cdb_alu;
	rs_pkg::cdb_t            cdb_mult;

	rs_pkg::data_t      exp_val [64];	// Shadow register file
	rs_pkg::rob_idx_t   exp_rob [64];
	rs_pkg::fu_select_t exp_fu [64];	// Bus the result must use
	bit                 pending [64];	// Dispatched, not yet broadcast
	bit                 done [64];	// Result seen on a bus
	bit                 seen [64];	// Broadcast already taken once
	rs_pkg::tag_t       recent [$];	// Latest destinations for dependencies
	rs_pkg::tag_t       mult_order [$];	// Expected multiply bus order
	rs_pkg::dispatch_t  idle_d;
	rs_pkg::tag_t       tag_ptr;
	rs_pkg::rob_idx_t   rob_next;
	bit                 order_check;
	integer             seed;
	int                 errors;
	int                 err_mark;
	int                 tests_run;
	int                 tests_failed;
	int                 completed;
	int                 last_sent;	// Slots driven at the previous edge
	int                 mult_run;	// Consecutive cycles with a product
	int                 mult_run_max;
	string              cur_test;

	rs_top #(.RS_ENTRIES(RS)) DUT
	(
		.clock      (clock),
		.reset      (reset),
		.disp0      (disp0),
		.disp1      (disp1),
		.free_count (free_count),
		.cdb_alu    (cdb_alu),
		.cdb_mult   (cdb_mult)
	);

	always #5 clock = ~clock;	// 10 ns period

	//////////////////////////////////////////////////
	// Reference model and helpers
	//////////////////////////////////////////////////

	function automatic rs_pkg::data_t ref_result(input rs_pkg::fu_select_t fu,
		input rs_pkg::alu_func_t f, input rs_pkg::data_t a, input rs_pkg::data_t b);
		rs_pkg::data_t r;
		if (fu == rs_pkg::FU_MULT)
			r = a * b;	// Low 64 bits of the product
		else
			case (f)
				rs_pkg::ALU_ADD: r = a + b;
				rs_pkg::ALU_SUB: r = a - b;
				rs_pkg::ALU_AND: r = a & b;
				rs_pkg::ALU_OR:  r = a | b;
				rs_pkg::ALU_XOR: r = a ^ b;
				default:         r = '0;
			endcase
		return r;
	endfunction

	function automatic int pick(input int n);
		return ($random(seed) & 32'h7fff_ffff) % n;	// Uniform-ish in 0..n-1
	endfunction

	function automatic rs_pkg::data_t rand64();
		rs_pkg::data_t v;
		v = {$random(seed), $random(seed)};
		return v;
	endfunction

	// Next tag with no result outstanding
	function automatic rs_pkg::tag_t alloc_tag();
		for (int i = 0; i < 64; i++)
		begin
			tag_ptr = tag_ptr + 1'b1;
			if (!pending[tag_ptr])
				return tag_ptr;
		end
		return tag_ptr;
	endfunction

	// Same-edge slot budget, grants only add room
	function automatic int avail();
		int a;
		a = int'(free_seen) - last_sent;
		if (a < 0)
			a = 0;
		return (a > 2) ? 2 : a;
	endfunction

	// Value if the producer is done, tag otherwise
	task automatic make_op(input bit dep, input rs_pkg::tag_t src,
		output rs_pkg::operand_t op, output rs_pkg::data_t val);
		if (dep && !done[src])
		begin
			op.ready = 1'b0;
			op.data  = '0;
			op.data[rs_pkg::TAG_W-1:0] = src;
			val = exp_val[src];	// Expected once it wakes
		end
		else
		begin
			val      = dep ? exp_val[src] : rand64();
			op.ready = 1'b1;
			op.data  = val;
		end
	endtask

	task automatic make_instr(input rs_pkg::fu_select_t fu, input rs_pkg::alu_func_t f,
		input bit dep_a, input rs_pkg::tag_t src_a, input bit dep_b,
		input rs_pkg::tag_t src_b, output rs_pkg::dispatch_t d);
		rs_pkg::operand_t oa;
		rs_pkg::operand_t ob;
		rs_pkg::data_t    va;
		rs_pkg::data_t    vb;
		rs_pkg::tag_t     dest;
		make_op(dep_a, src_a, oa, va);
		make_op(dep_b, src_b, ob, vb);
		dest = alloc_tag();	// After operands, program order
		exp_val[dest] = ref_result(fu, f, va, vb);
		exp_rob[dest] = rob_next;
		exp_fu[dest]  = fu;
		pending[dest] = 1'b1;
		done[dest]    = 1'b0;
		seen[dest]    = 1'b0;
		d = '{valid: 1'b1, fu_select: fu, func: f, dest: dest, rob_idx: rob_next,
			opa: oa, opb: ob};
		rob_next = rob_next + 1'b1;
		recent.push_back(dest);
		if (recent.size() > 6)
			void'(recent.pop_front());
	endtask

	task automatic rand_instr(input bit with_deps, output rs_pkg::dispatch_t d);
		rs_pkg::fu_select_t fu;
		rs_pkg::alu_func_t  f;
		bit                 da;
		bit                 db;
		rs_pkg::tag_t       sa;
		rs_pkg::tag_t       sb;
		fu = with_deps ? rs_pkg::fu_select_t'(pick(2)) : rs_pkg::FU_ALU;
		f  = rs_pkg::alu_func_t'(pick(5));
		da = with_deps && (recent.size() > 0) && pick(2);
		db = with_deps && (recent.size() > 0) && pick(2);
		sa = da ? recent[pick(recent.size())] : '0;
		sb = db ? recent[pick(recent.size())] : '0;
		make_instr(fu, f, da, sa, db, sb, d);
	endtask

	// Call right after a rising edge
	task automatic drive(input rs_pkg::dispatch_t d0, input rs_pkg::dispatch_t d1);
		disp0 <= d0;
		disp1 <= d1;
		last_sent = int'(d0.valid) + int'(d1.valid);
	endtask

	task automatic timeout_fail(input string what);
		$display("Timeout in %s while waiting for %s", cur_test, what);
		$display("TEST RESULT: FAIL");
		$finish;
	endtask

	task automatic wait_drain(input int limit);
		int  n;
		bit  left;
		n    = 0;
		left = 1'b1;
		while (left)
		begin
			@(posedge clock);
			drive(idle_d, idle_d);
			left = (free_seen != RS);
			for (int t = 0; t < 64; t++)
				if (pending[t])
					left = 1'b1;
			n++;
			if (n > limit)
				timeout_fail("outstanding results");
		end
	endtask

	// Stream of instructions within the free budget
	task automatic run_stream(input int count, input bit with_deps, input int limit);
		rs_pkg::dispatch_t d0;
		rs_pkg::dispatch_t d1;
		int                k;
		int                n;
		n = 0;
		while (count > 0)
		begin
			@(posedge clock);
			k  = avail();
			d0 = idle_d;
			d1 = idle_d;
			if (k > 0)
			begin
				rand_instr(with_deps, d0);
				count--;
			end
			if ((k > 1) && (count > 0))
			begin
				rand_instr(with_deps, d1);
				count--;
			end
			drive(d0, d1);
			n++;
			if (n > limit)
				timeout_fail("dispatch room");
		end
		wait_drain(limit);
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		err_mark = errors;
	endtask

	task automatic end_test();
		tests_run++;
		if (errors > err_mark)
			tests_failed++;
		$display("Test %-14s %s, %0d errors", cur_test,
			(errors > err_mark) ? "failed" : "ok", errors - err_mark);
	endtask

	//////////////////////////////////////////////////
	// Scoreboard
	//////////////////////////////////////////////////

	task automatic check_bus(input rs_pkg::cdb_t bus, input rs_pkg::fu_select_t fu);
		bit known;
		known = pending[bus.tag];
		if (bus.valid)
		begin
			assert (known)
			else
			begin
				if (seen[bus.tag])
					$display("Duplicate broadcast of tag %0d in %s", bus.tag, cur_test);
				else
					$display("Broadcast of unknown tag %0d in %s", bus.tag, cur_test);
				errors++;
			end
			if (known)
			begin
				assert (exp_fu[bus.tag] == fu)
				else
				begin
					$display("Tag %0d came back on the wrong bus in %s", bus.tag, cur_test);
					errors++;
				end
				assert (bus.rob_idx == exp_rob[bus.tag])
				else
				begin
					$display("[FAIL] %s rob of tag %0d expected %0d actual %0d", cur_test,
						bus.tag, exp_rob[bus.tag], bus.rob_idx);
					errors++;
				end
				assert (bus.data == exp_val[bus.tag])
				else
				begin
					$display("[FAIL] %s value of tag %0d expected %h actual %h", cur_test,
						bus.tag, exp_val[bus.tag], bus.data);
					errors++;
				end
				pending[bus.tag] = 1'b0;
				done[bus.tag]    = 1'b1;
				seen[bus.tag]    = 1'b1;
				completed++;
			end
			if (order_check && (fu == rs_pkg::FU_MULT))
			begin
				assert ((mult_order.size() > 0) && (bus.tag == mult_order[0]))
				else
				begin
					$display("[FAIL] %s multiply order expected %0d actual %0d", cur_test,
						(mult_order.size() > 0) ? mult_order[0] : 0, bus.tag);
					errors++;
				end
				if (mult_order.size() > 0)
					void'(mult_order.pop_front());
			end
		end
	endtask

	always @(negedge clock)	// Buses settled mid-cycle
	begin
		free_seen = free_count;	// Budget for the next rising edge
		if (!reset)
		begin
			check_bus(cdb_alu, rs_pkg::FU_ALU);
			check_bus(cdb_mult, rs_pkg::FU_MULT);
			mult_run = cdb_mult.valid ? mult_run + 1 : 0;	// Back-to-back products
			if (mult_run > mult_run_max)
				mult_run_max = mult_run;
		end
	end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	initial
	begin
		rs_pkg::dispatch_t d0;
		rs_pkg::dispatch_t d1;
		rs_pkg::tag_t      prod;
		rs_pkg::tag_t      cons;
		int                n;
		bit                filled;
		clock        = 1'b0;
		reset        = 1'b1;
		idle_d       = '0;
		disp0        = '0;
		disp1        = '0;
		seed         = 32'h39ce0bd9;
		tag_ptr      = '0;
		rob_next     = '0;
		order_check  = 1'b0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		completed    = 0;
		last_sent    = 0;
		free_seen    = '0;
		mult_run     = 0;
		mult_run_max = 0;
		for (int t = 0; t < 64; t++)
		begin
			pending[t] = 1'b0;
			done[t]    = 1'b0;
			seen[t]    = 1'b0;
			exp_val[t] = '0;
		end
		repeat (2) @(posedge clock);
		reset <= 1'b0;

		start_test("reset_state");
		@(negedge clock);
		assert (free_count == RS)
		else
		begin
			$display("[FAIL] %s free_count expected %0d actual %0d", cur_test, RS, free_count);
			errors++;
		end
		repeat (4)
		begin
			@(negedge clock);
			assert (!cdb_alu.valid && !cdb_mult.valid)
			else
			begin
				$display("A bus went valid with nothing dispatched");
				errors++;
			end
		end
		end_test();

		start_test("alu_pairs");
		run_stream(16, 1'b0, 200);
		end_test();

		start_test("mult_stream");
		order_check  = 1'b1;
		mult_run_max = 0;
		for (int i = 0; i < 6; i++)	// One per cycle keeps issue order
		begin
			@(posedge clock);
			make_instr(rs_pkg::FU_MULT, rs_pkg::ALU_ADD, 0, '0, 0, '0, d0);
			mult_order.push_back(d0.dest);
			drive(d0, idle_d);
		end
		wait_drain(100);
		order_check = 1'b0;
		assert (mult_run_max >= 6)
		else
		begin
			$display("[FAIL] %s back-to-back products expected %0d actual %0d", cur_test,
				6, mult_run_max);
			errors++;
		end
		end_test();

		start_test("dep_chains");
		@(posedge clock);
		make_instr(rs_pkg::FU_ALU, rs_pkg::ALU_SUB, 0, '0, 0, '0, d0);
		prod = d0.dest;
		drive(d0, idle_d);
		@(posedge clock);
		drive(idle_d, idle_d);
		@(posedge clock);	// Producer is on cdb_alu this cycle
		make_instr(rs_pkg::FU_ALU, rs_pkg::ALU_XOR, 1, prod, 0, '0, d0);
		cons = d0.dest;
		drive(d0, idle_d);
		@(posedge clock);
		make_instr(rs_pkg::FU_MULT, rs_pkg::ALU_ADD, 0, '0, 0, '0, d0);
		prod = d0.dest;
		drive(d0, idle_d);
		repeat (rs_pkg::MULT_STAGES)
		begin
			@(posedge clock);
			drive(idle_d, idle_d);
		end
		@(posedge clock);	// Product is on cdb_mult this cycle
		make_instr(rs_pkg::FU_MULT, rs_pkg::ALU_ADD, 1, prod, 1, cons, d0);
		make_instr(rs_pkg::FU_ALU, rs_pkg::ALU_ADD, 1, d0.dest, 1, prod, d1);
		drive(d0, d1);
		for (int i = 0; i < 4; i++)	// Mixed pairs chained on recent results
		begin
			@(posedge clock);
			make_instr(rs_pkg::FU_MULT, rs_pkg::ALU_ADD, 1, recent[recent.size()-1],
				1, recent[recent.size()-2], d0);
			make_instr(rs_pkg::FU_ALU, rs_pkg::alu_func_t'(i), 1, d0.dest, 0, '0, d1);
			drive(d0, d1);
			@(posedge clock);
			drive(idle_d, idle_d);
		end
		wait_drain(200);
		end_test();

		start_test("full_station");
		filled = 1'b0;
		n      = 0;
		prod   = '0;
		d1     = idle_d;
		while (!filled)
		begin
			@(posedge clock);
			if (free_seen == 0)
			begin
				filled = 1'b1;
				drive(idle_d, idle_d);
			end
			else
			begin
				d0 = idle_d;
				d1 = idle_d;
				if (avail() > 0)
				begin
					make_instr(rs_pkg::FU_MULT, rs_pkg::ALU_ADD, n > 0, prod, 0, '0, d0);
					prod = d0.dest;
				end
				if (avail() > 1)
				begin
					make_instr(rs_pkg::FU_MULT, rs_pkg::ALU_ADD, 1, prod, 0, '0, d1);
					prod = d1.dest;
				end
				drive(d0, d1);
			end
			n++;
			if (n > 100)
				timeout_fail("free_count to reach 0");
		end
		wait_drain(400);
		end_test();

		start_test("random_mix");
		run_stream(200, 1'b1, 3000);
		end_test();

		$display("Summary: %0d tests, %0d failed, %0d results checked, %0d errors",
			tests_run, tests_failed, completed, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* common/rs_pkg.sv */
`default_nettype none

package rs_pkg;

	//////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////

	localparam int DATA_W      = 64;	// Operand and result width
	localparam int TAG_W       = 6;	// 64 physical registers
	localparam int ROB_W       = 5;	// 32 ROB slots
	localparam int MULT_STAGES = 3;	// Multiplier latency in cycles

	typedef logic [DATA_W-1:0] data_t;	// Operand or result value
	typedef logic [TAG_W-1:0]  tag_t;	// Physical register tag
	typedef logic [ROB_W-1:0]  rob_idx_t;	// Reorder buffer slot

	//////////////////////////////////////////////////
	// Encodings
	//////////////////////////////////////////////////

	typedef enum logic
	{
		FU_ALU  = 1'b0,	// Single-cycle integer unit
		FU_MULT = 1'b1	// Pipelined multiplier
	} fu_select_t;

	typedef enum logic [2:0]
	{
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4
	} alu_func_t;

	//////////////////////////////////////////////////
	// Bundles
	//////////////////////////////////////////////////

	// While ready is low the low TAG_W bits of data name the producer
	typedef struct packed
	{
		logic  ready;	// Value present
		data_t data;	// Value or producer tag
	} operand_t;

	typedef struct packed
	{
		logic       valid;	// One-cycle strobe
		fu_select_t fu_select;	// Target unit
		alu_func_t  func;	// ALU operation, ignored by multiplier
		tag_t       dest;	// Destination physical register
		rob_idx_t   rob_idx;	// ROB slot
		operand_t   opa;
		operand_t   opb;
	} dispatch_t;

	typedef struct packed
	{
		logic      valid;	// One-cycle strobe
		alu_func_t func;
		tag_t      dest;
		rob_idx_t  rob_idx;
		data_t     opa;	// Both operands resolved
		data_t     opb;
	} issue_t;

	typedef struct packed
	{
		logic     valid;	// One cycle per result
		tag_t     tag;	// Producer tag being woken
		rob_idx_t rob_idx;
		data_t    data;	// Result value
	} cdb_t;

endpackage

`default_nettype wire

/* logic/alu_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_unit
(
	input  wire logic      clock,
	input  wire logic      reset,
	input  rs_pkg::issue_t issue,	// From selector, one-cycle strobe
	output rs_pkg::cdb_t   cdb	// Registered broadcast
);

	rs_pkg::data_t result;	// Combinational result

	//////////////////////////////////////////////////
	// Operation decode
	//////////////////////////////////////////////////

	always_comb
	begin
		case (issue.func)
			rs_pkg::ALU_ADD: result = issue.opa + issue.opb;
			rs_pkg::ALU_SUB: result = issue.opa - issue.opb;
			rs_pkg::ALU_AND: result = issue.opa & issue.opb;
			rs_pkg::ALU_OR:  result = issue.opa | issue.opb;
			rs_pkg::ALU_XOR: result = issue.opa ^ issue.opb;
			default:         result = '0;	// Unused encodings
		endcase
	end

	// Result goes out the cycle after grant
	always_ff @(posedge clock)
	begin
		cdb.tag     <= issue.dest;
		cdb.rob_idx <= issue.rob_idx;
		cdb.data    <= result;
		if (reset)
			cdb.valid <= 1'b0;	// Bus quiet after reset
		else
			cdb.valid <= issue.valid;
	end

endmodule

`default_nettype wire

/* logic/mult_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module mult_unit
(
	input  wire logic      clock,
	input  wire logic      reset,
	input  rs_pkg::issue_t issue,	// From selector, one-cycle strobe
	output rs_pkg::cdb_t   cdb	// Broadcast MULT_STAGES after grant
);

	// Bookkeeping that rides along each stage
	typedef struct packed
	{
		logic             valid;
		rs_pkg::tag_t     tag;
		rs_pkg::rob_idx_t rob_idx;
	} ctl_t;

	ctl_t          ctl_q [rs_pkg::MULT_STAGES];	// Per-stage control
	rs_pkg::data_t a_q;	// Stage 1 operands
	rs_pkg::data_t b_q;
	logic [63:0]   ll_q;	// Stage 2 low x low
	logic [31:0]   lh_q;	// Cross terms, only low halves reach bit 63
	logic [31:0]   hl_q;
	rs_pkg::data_t prod_q;	// Stage 3 low 64 bits

	//////////////////////////////////////////////////
	// Datapath
	//////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		a_q    <= issue.opa;	// Stage 1
		b_q    <= issue.opb;
		ll_q   <= a_q[31:0] * b_q[31:0];	// Stage 2, 32x32 products
		lh_q   <= 32'(a_q[31:0] * b_q[63:32]);
		hl_q   <= 32'(a_q[63:32] * b_q[31:0]);
		prod_q <= ll_q + {lh_q + hl_q, 32'd0};	// Stage 3, fold cross terms
	end

	// Control shift register
	always_ff @(posedge clock)
	begin
		ctl_q[0] <= '{valid: issue.valid, tag: issue.dest, rob_idx: issue.rob_idx};
		for (int i = 1; i < rs_pkg::MULT_STAGES; i++)
			ctl_q[i] <= ctl_q[i-1];
		if (reset)
			for (int i = 0; i < rs_pkg::MULT_STAGES; i++)
				ctl_q[i].valid <= 1'b0;	// Flush in-flight ops
	end

	assign cdb = '{
		valid:   ctl_q[rs_pkg::MULT_STAGES-1].valid,
		tag:     ctl_q[rs_pkg::MULT_STAGES-1].tag,
		rob_idx: ctl_q[rs_pkg::MULT_STAGES-1].rob_idx,
		data:    prod_q
	};

endmodule

`default_nettype wire

/* logic/rs_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rs_top
#(
	parameter int RS_ENTRIES = 8
)
(
	input  wire logic                        clock,
	input  wire logic                        reset,
	input  rs_pkg::dispatch_t                disp0,	// Older dispatch slot
	input  rs_pkg::dispatch_t                disp1,	// Younger dispatch slot
	output logic [$clog2(RS_ENTRIES+1)-1:0]  free_count,
	output rs_pkg::cdb_t                     cdb_alu,
	output rs_pkg::cdb_t                     cdb_mult
);

	logic [RS_ENTRIES-1:0]               entry_busy;
	logic [RS_ENTRIES-1:0]               entry_ready;
	logic [RS_ENTRIES-1:0]               entry_load;	// Allocator strobes
	logic [RS_ENTRIES-1:0]               entry_grant;	// Selector strobes
	rs_pkg::dispatch_t [RS_ENTRIES-1:0]  entry_load_data;
	rs_pkg::fu_select_t [RS_ENTRIES-1:0] entry_fu;
	rs_pkg::issue_t [RS_ENTRIES-1:0]     entry_issue;
	rs_pkg::issue_t                      alu_issue;
	rs_pkg::issue_t                      mult_issue;

	//////////////////////////////////////////////////
	// Input side
	//////////////////////////////////////////////////

	rs_alloc #(.RS_ENTRIES(RS_ENTRIES)) u_alloc
	(
		.disp0      (disp0),
		.disp1      (disp1),
		.entry_busy (entry_busy),
		.load       (entry_load),
		.load_data  (entry_load_data),
		.free_count (free_count)
	);

	// Entry array, both buses fed back to every entry
	for (genvar i = 0; i < RS_ENTRIES; i++)
	begin : gen_entry
		rs_entry u_entry
		(
			.clock     (clock),
			.reset     (reset),
			.load      (entry_load[i]),
			.load_data (entry_load_data[i]),
			.cdb_alu   (cdb_alu),
			.cdb_mult  (cdb_mult),
			.grant     (entry_grant[i]),
			.busy      (entry_busy[i]),
			.ready     (entry_ready[i]),
			.fu_select (entry_fu[i]),
			.issue     (entry_issue[i])
		);
	end

	//////////////////////////////////////////////////
	// Output side
	//////////////////////////////////////////////////

	rs_issue_select #(.RS_ENTRIES(RS_ENTRIES)) u_select
	(
		.entry_ready (entry_ready),
		.entry_fu    (entry_fu),
		.entry_issue (entry_issue),
		.grant       (entry_grant),
		.alu_issue   (alu_issue),
		.mult_issue  (mult_issue)
	);

	alu_unit u_alu
	(
		.clock (clock),
		.reset (reset),
		.issue (alu_issue),
		.cdb   (cdb_alu)
	);

	mult_unit u_mult
	(
		.clock (clock),
		.reset (reset),
		.issue (mult_issue),
		.cdb   (cdb_mult)
	);

endmodule

`default_nettype wire

/* rs/rs_alloc.sv */
`timescale 1ns/1ps
`default_nettype none

module rs_alloc
#(
	parameter int RS_ENTRIES = 8
)
(
	input  rs_pkg::dispatch_t                   disp0,	// Older slot
	input  rs_pkg::dispatch_t                   disp1,	// Younger slot
	input  wire logic [RS_ENTRIES-1:0]          entry_busy,
	output logic [RS_ENTRIES-1:0]               load,	// One strobe per entry
	output rs_pkg::dispatch_t [RS_ENTRIES-1:0]  load_data,
	output logic [$clog2(RS_ENTRIES+1)-1:0]     free_count
);

	localparam int IDX_W = $clog2(RS_ENTRIES);
	localparam int CNT_W = $clog2(RS_ENTRIES+1);

	logic [IDX_W-1:0] first_idx;	// Lowest idle entry
	logic [IDX_W-1:0] second_idx;	// Next idle entry
	logic             first_found;
	logic             second_found;

	//////////////////////////////////////////////////
	// Priority search for two idle entries
	//////////////////////////////////////////////////

	always_comb
	begin
		first_idx    = '0;
		second_idx   = '0;
		first_found  = 1'b0;
		second_found = 1'b0;
		for (int i = 0; i < RS_ENTRIES; i++)
		begin
			if (!entry_busy[i])
			begin
				if (!first_found)
				begin
					first_found = 1'b1;
					first_idx   = IDX_W'(i);
				end
				else if (!second_found)
				begin
					second_found = 1'b1;
					second_idx   = IDX_W'(i);
				end
			end
		end
	end

	// Steering, a lone disp1 takes the first slot
	always_comb
	begin
		load = '0;
		for (int i = 0; i < RS_ENTRIES; i++)
			load_data[i] = disp0;	// Payload only matters with load
		if (disp0.valid && first_found)
		begin
			load[first_idx]      = 1'b1;
			load_data[first_idx] = disp0;
			if (disp1.valid && second_found)
			begin
				load[second_idx]      = 1'b1;	// Younger behind older
				load_data[second_idx] = disp1;
			end
		end
		else if (disp1.valid && first_found)
		begin
			load[first_idx]      = 1'b1;	// Compacted
			load_data[first_idx] = disp1;
		end
	end

	// Idle count at cycle start
	always_comb
	begin
		free_count = '0;
		for (int i = 0; i < RS_ENTRIES; i++)
			if (!entry_busy[i])
				free_count = free_count + CNT_W'(1);
	end

endmodule

`default_nettype wire

/* rs/rs_entry.sv */
`timescale 1ns/1ps
`default_nettype none

module rs_entry
(
	input  wire logic            clock,
	input  wire logic            reset,
	input  wire logic            load,	// Take load_data this edge
	input  rs_pkg::dispatch_t    load_data,
	input  rs_pkg::cdb_t         cdb_alu,	// ALU result bus
	input  rs_pkg::cdb_t         cdb_mult,	// Multiplier result bus
	input  wire logic            grant,	// Sent to a unit, free next edge
	output logic                 busy,
	output logic                 ready,
	output rs_pkg::fu_select_t   fu_select,
	output rs_pkg::issue_t       issue
);

	//////////////////////////////////////////////////
	// Held instruction
	//////////////////////////////////////////////////

	rs_pkg::operand_t   opa_q;	// Operand A, value or tag
	rs_pkg::operand_t   opb_q;	// Operand B, value or tag
	rs_pkg::fu_select_t fu_q;	// Unit class
	rs_pkg::alu_func_t  func_q;	// ALU op
	rs_pkg::tag_t       dest_q;	// Destination tag
	rs_pkg::rob_idx_t   rob_q;	// ROB slot

	// Snoop both buses for a waiting operand
	// Tags are unique in flight, so at most one bus can hit
	function automatic rs_pkg::operand_t wake(input rs_pkg::operand_t op);
		rs_pkg::operand_t res;
		res = op;
		if (!op.ready && cdb_alu.valid &&
			(cdb_alu.tag == op.data[rs_pkg::TAG_W-1:0]))
		begin
			res.ready = 1'b1;	// Hit on ALU bus
			res.data  = cdb_alu.data;
		end
		if (!op.ready && cdb_mult.valid &&
			(cdb_mult.tag == op.data[rs_pkg::TAG_W-1:0]))
		begin
			res.ready = 1'b1;	// Hit on multiplier bus
			res.data  = cdb_mult.data;
		end
		return res;
	endfunction

	//////////////////////////////////////////////////
	// Occupancy
	//////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
			busy <= 1'b0;	// All entries idle
		else if (load)
			busy <= 1'b1;	// Allocator only loads idle entries
		else if (grant)
			busy <= 1'b0;	// Leaves for its unit
	end

	//////////////////////////////////////////////////
	// Operand capture
	//////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (load)
		begin
			opa_q  <= wake(load_data.opa);	// Same-cycle broadcast caught here
			opb_q  <= wake(load_data.opb);
			fu_q   <= load_data.fu_select;
			func_q <= load_data.func;
			dest_q <= load_data.dest;
			rob_q  <= load_data.rob_idx;
		end
		else
		begin
			opa_q <= wake(opa_q);	// Keep snooping while waiting
			opb_q <= wake(opb_q);
		end
	end

	// Ready once both values are in hand
	assign ready     = busy && opa_q.ready && opb_q.ready;
	assign fu_select = fu_q;

	// Packet the selector would forward on grant
	assign issue = '{
		valid:   ready,
		func:    func_q,
		dest:    dest_q,
		rob_idx: rob_q,
		opa:     opa_q.data,
		opb:     opb_q.data
	};

endmodule

`default_nettype wire

/* rs/rs_issue_select.sv */
`timescale 1ns/1ps
`default_nettype none

module rs_issue_select
#(
	parameter int RS_ENTRIES = 8
)
(
	input  wire logic [RS_ENTRIES-1:0]           entry_ready,
	input  rs_pkg::fu_select_t [RS_ENTRIES-1:0]  entry_fu,	// Unit class per entry
	input  rs_pkg::issue_t [RS_ENTRIES-1:0]      entry_issue,	// Candidate packets
	output logic [RS_ENTRIES-1:0]                grant,	// At most one per class
	output rs_pkg::issue_t                       alu_issue,
	output rs_pkg::issue_t                       mult_issue
);

	localparam int IDX_W = $clog2(RS_ENTRIES);

	logic [IDX_W-1:0] alu_idx;	// Winning ALU entry
	logic [IDX_W-1:0] mult_idx;	// Winning multiply entry
	logic             alu_found;
	logic             mult_found;

	//////////////////////////////////////////////////
	// Lowest-index ready entry per class
	//////////////////////////////////////////////////

	always_comb
	begin
		alu_idx    = '0;
		mult_idx   = '0;
		alu_found  = 1'b0;
		mult_found = 1'b0;
		for (int i = 0; i < RS_ENTRIES; i++)
		begin
			if (entry_ready[i])
			begin
				if ((entry_fu[i] == rs_pkg::FU_ALU) && !alu_found)
				begin
					alu_found = 1'b1;
					alu_idx   = IDX_W'(i);
				end
				else if ((entry_fu[i] == rs_pkg::FU_MULT) && !mult_found)
				begin
					mult_found = 1'b1;
					mult_idx   = IDX_W'(i);
				end
			end
		end
	end

	// One-hot grants, both units take one op per cycle
	always_comb
	begin
		grant = '0;
		if (alu_found)
			grant[alu_idx] = 1'b1;
		if (mult_found)
			grant[mult_idx] = 1'b1;
	end

	//////////////////////////////////////////////////
	// Issue packets
	//////////////////////////////////////////////////

	always_comb
	begin
		alu_issue       = entry_issue[alu_idx];
		alu_issue.valid = alu_found;	// Strobe only with a grant
	end

	always_comb
	begin
		mult_issue       = entry_issue[mult_idx];
		mult_issue.valid = mult_found;
	end

endmodule

`default_nettype wire

/* tb.f */
common/rs_pkg.sv
rs/rs_entry.sv
rs/rs_alloc.sv
rs/rs_issue_select.sv
logic/alu_unit.sv
logic/mult_unit.sv
logic/rs_top.sv
bench/tb_rs_top.sv
